//--- rtl/lsqPkg.sv
// Load/store queue package
// queue sizes, address and data widths, access size codes
// and the index, address and data types shared by the load path
package lsqPkg;

	// queue sizes
	localparam int StqDepth = 8;
	localparam int LdqDepth = 8;

	// datapath widths
	localparam int DataW   = 32;
	localparam int AddrW   = 32;
	// byte offset inside a word
	localparam int OffsetW = 2;

	// store queue index and occupancy, occupancy needs one extra bit for full
	typedef logic [$clog2(StqDepth)-1:0] stqIdx_t;
	typedef logic [$clog2(StqDepth):0]   stqCnt_t;

	// load queue index
	typedef logic [$clog2(LdqDepth)-1:0] ldqIdx_t;

	// payload types
	typedef logic [AddrW-1:0] addr_t;
	typedef logic [DataW-1:0] data_t;

	// access size, larger code is a wider access
	typedef logic [1:0] memSize_t;

	localparam memSize_t SizeByte = 2'd0;
	localparam memSize_t SizeHalf = 2'd1;
	localparam memSize_t SizeWord = 2'd2;

endpackage

//--- rtl/storeQueue.sv
// Store queue
// holds address, data and size of each in-flight store, one address-valid
// bit per entry and the circular head/tail pointers with occupancy.
// Compares the presented load against every entry and serves two read
// ports: the commit head and the forwarding index.
`timescale 1ns/1ps

module storeQueue (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          stDispatch_i,
	input  logic                          stExec_i,
	input  lsqPkg::stqIdx_t               stExecId_i,
	input  lsqPkg::addr_t                 stAddr_i,
	input  lsqPkg::data_t                 stData_i,
	input  lsqPkg::memSize_t              stSize_i,
	input  logic                          commitSt_i,
	input  lsqPkg::addr_t                 ldAddr_i,
	input  lsqPkg::memSize_t              ldSize_i,
	input  lsqPkg::stqIdx_t               fwdIdx_i,
	output lsqPkg::stqIdx_t               head_o,
	output lsqPkg::stqIdx_t               tail_o,
	output lsqPkg::stqCnt_t               count_o,
	output logic [lsqPkg::StqDepth-1:0]   addrValid_o,
	output logic [lsqPkg::StqDepth-1:0]   wordMatch_o,
	output logic [lsqPkg::StqDepth-1:0]   offsetMatch_o,
	output logic [lsqPkg::StqDepth-1:0]   sizeSmall_o,
	output lsqPkg::data_t                 fwdData_o,
	output lsqPkg::addr_t                 stCommitAddr_o,
	output lsqPkg::data_t                 stCommitData_o,
	output lsqPkg::memSize_t              stCommitSize_o
);
	import lsqPkg::*;

	// entry payload, written when the store executes
	addr_t    stqAddr [StqDepth];
	data_t    stqData [StqDepth];
	memSize_t stqSize [StqDepth];

	logic [StqDepth-1:0] addrValid;
	stqIdx_t             head;
	stqIdx_t             tail;
	stqCnt_t             count;
	memSize_t            ldSizeN;

	// reserved size code 3 behaves as a word access
	assign ldSizeN = (ldSize_i > SizeWord) ? SizeWord : ldSize_i;

	always_ff @(posedge clk)
	begin
		if (stExec_i)
		begin
			stqAddr[stExecId_i] <= stAddr_i;
			stqData[stExecId_i] <= stData_i;
			stqSize[stExecId_i] <= (stSize_i > SizeWord) ? SizeWord : stSize_i;
		end
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			head      <= '0;
			tail      <= '0;
			count     <= '0;
			addrValid <= '0;
		end
		else
		begin
			// commit retires the head entry
			if (commitSt_i)
			begin
				addrValid[head] <= 1'b0;
				head            <= head + 1'b1;
			end
			// address known from execute onward
			if (stExec_i)
				addrValid[stExecId_i] <= 1'b1;
			if (stDispatch_i)
				tail <= tail + 1'b1;
			// dispatch and commit in one cycle leave the count unchanged
			case ({stDispatch_i, commitSt_i})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// word, offset and size compare against every entry
	always_comb
	begin
		for (int i = 0; i < StqDepth; i++)
		begin
			wordMatch_o[i]   = (stqAddr[i][AddrW-1:OffsetW] == ldAddr_i[AddrW-1:OffsetW]);
			offsetMatch_o[i] = (stqAddr[i][OffsetW-1:0] == ldAddr_i[OffsetW-1:0]);
			// store narrower than the load
			sizeSmall_o[i]   = (stqSize[i] < ldSizeN);
		end
	end

	assign head_o      = head;
	assign tail_o      = tail;
	assign count_o     = count;
	assign addrValid_o = addrValid;

	// forwarding read port
	assign fwdData_o = stqData[fwdIdx_i];

	// commit read port, valid while not empty
	assign stCommitAddr_o = stqAddr[head];
	assign stCommitData_o = stqData[head];
	assign stCommitSize_o = stqSize[head];

endmodule

//--- rtl/loadQueue.sv
// Load queue table
// per load, the index of the youngest store older than it at dispatch
// and whether that record still names a store in the queue
`timescale 1ns/1ps

module loadQueue (
	input  logic             clk,
	input  logic             reset,
	input  logic             ldDispatch_i,
	input  lsqPkg::ldqIdx_t  ldDispatchId_i,
	input  logic             commitLd_i,
	input  lsqPkg::ldqIdx_t  commitLdId_i,
	input  logic             commitSt_i,
	input  lsqPkg::stqIdx_t  stqHead_i,
	input  lsqPkg::stqIdx_t  stqTail_i,
	input  lsqPkg::stqCnt_t  stqCount_i,
	input  lsqPkg::ldqIdx_t  ldId_i,
	output lsqPkg::stqIdx_t  lastSt_o,
	output logic             lastStValid_o
);
	import lsqPkg::*;

	stqIdx_t             lastSt [LdqDepth];
	logic [LdqDepth-1:0] lastStValid;
	stqCnt_t             stqCntAfter;
	logic                stqLive;

	// occupancy after a same-cycle store commit
	assign stqCntAfter = stqCount_i - stqCnt_t'(commitSt_i);
	assign stqLive     = (stqCntAfter != '0);

	// youngest older store is the one just behind the tail
	always_ff @(posedge clk)
	begin
		if (ldDispatch_i)
			lastSt[ldDispatchId_i] <= stqTail_i - 1'b1;
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			lastStValid <= '0;
		end
		else
		begin
			// head store leaving, so every load naming it has no older store left
			if (commitSt_i)
			begin
				for (int i = 0; i < LdqDepth; i++)
				begin
					if (lastSt[i] == stqHead_i)
						lastStValid[i] <= 1'b0;
				end
			end
			if (commitLd_i)
				lastStValid[commitLdId_i] <= 1'b0;
			// new load record overrides any clear above
			if (ldDispatch_i)
				lastStValid[ldDispatchId_i] <= stqLive;
		end
	end

	// executing load's record
	assign lastSt_o      = lastSt[ldId_i];
	assign lastStValid_o = lastStValid[ldId_i];

endmodule

//--- rtl/loadDisambig.sv
// Load disambiguation
// builds the window of stores older than the executing load, forms the
// full-match and partial-match vectors over it and finds the youngest
// full match for forwarding
`timescale 1ns/1ps

module loadDisambig (
	input  lsqPkg::stqIdx_t               stqHead_i,
	input  lsqPkg::stqIdx_t               lastSt_i,
	input  logic                          lastStValid_i,
	input  logic [lsqPkg::StqDepth-1:0]   addrValid_i,
	input  logic [lsqPkg::StqDepth-1:0]   wordMatch_i,
	input  logic [lsqPkg::StqDepth-1:0]   offsetMatch_i,
	input  logic [lsqPkg::StqDepth-1:0]   sizeSmall_i,
	output logic                          fwdHit_o,
	output lsqPkg::stqIdx_t               fwdIdx_o,
	output logic                          partialMatch_o
);
	import lsqPkg::*;

	logic                stqWrap;
	logic [StqDepth-1:0] winNoWrap;
	logic [StqDepth-1:0] winWrap;
	logic [StqDepth-1:0] window;
	logic [StqDepth-1:0] fullVec;
	logic [StqDepth-1:0] partialVec;

	// window wraps past the top of the array
	assign stqWrap = (stqHead_i > lastSt_i);

	// head through last older store, both shapes
	always_comb
	begin
		for (int i = 0; i < StqDepth; i++)
		begin
			winNoWrap[i] = (stqIdx_t'(i) >= stqHead_i) && (stqIdx_t'(i) <= lastSt_i);
			winWrap[i]   = (stqIdx_t'(i) <= lastSt_i) || (stqIdx_t'(i) >= stqHead_i);
		end
	end

	// no valid record means no older store to check
	assign window = !lastStValid_i ? '0 : (stqWrap ? winWrap : winNoWrap);

	// same word, same offset, store at least as wide
	assign fullVec    = addrValid_i & window & wordMatch_i & offsetMatch_i & ~sizeSmall_i;
	// same word but other bytes or too few of them
	assign partialVec = addrValid_i & window & wordMatch_i & (~offsetMatch_i | sizeSmall_i);

	// scan oldest to youngest, later hits overwrite earlier ones
	always_comb
	begin : youngestMatch
		stqIdx_t idx;

		fwdHit_o       = 1'b0;
		fwdIdx_o       = '0;
		partialMatch_o = 1'b0;
		for (int k = 0; k < StqDepth; k++)
		begin
			idx = stqHead_i + stqIdx_t'(k);
			if (fullVec[idx])
			begin
				fwdHit_o       = 1'b1;
				fwdIdx_o       = idx;
				// younger full store covers an older partial one
				partialMatch_o = 1'b0;
			end
			if (partialVec[idx])
				partialMatch_o = 1'b1;
		end
	end

endmodule

//--- rtl/loadIssueCtrl.sv
// Load issue control
// four-phase load handshake, registers the lookup on acceptance and runs
// a four-phase memory read for loads not served from the store queue
`timescale 1ns/1ps

module loadIssueCtrl (
	input  logic           clk,
	input  logic           reset,
	input  logic           ldReq_i,
	input  lsqPkg::addr_t  ldAddr_i,
	input  logic           fwdHit_i,
	input  logic           partialMatch_i,
	input  lsqPkg::data_t  fwdData_i,
	input  logic           memAck_i,
	input  lsqPkg::data_t  memData_i,
	output logic           ldAck_o,
	output lsqPkg::data_t  ldData_o,
	output logic           ldFwd_o,
	output logic           ldViolate_o,
	output logic           memReq_o,
	output lsqPkg::addr_t  memAddr_o
);
	import lsqPkg::*;

	typedef enum logic [2:0] {StIdle, StFwd, StMemReq, StMemRel, StAck, StAckRel} state_t;

	state_t state;
	logic   ldAckQ;
	logic   memReqQ;
	logic   accept;
	logic   memDone;
	logic   fwdQ;
	logic   violQ;
	data_t  resultQ;
	addr_t  memAddrQ;

	// new load only from idle
	assign accept  = (state == StIdle) && ldReq_i;
	// memory data arriving
	assign memDone = (state == StMemReq) && memReqQ && memAck_i;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state   <= StIdle;
			ldAckQ  <= 1'b0;
			memReqQ <= 1'b0;
		end
		else
		begin
			case (state)
				StIdle:
					if (ldReq_i)
						state <= fwdHit_i ? StFwd : StMemReq;
				// result ready, ack goes up on this edge
				StFwd:
				begin
					ldAckQ <= 1'b1;
					state  <= StAck;
				end
				StMemReq:
				begin
					if (!memReqQ)
						memReqQ <= 1'b1;
					else if (memAck_i)
					begin
						memReqQ <= 1'b0;
						state   <= StMemRel;
					end
				end
				// wait for memory to drop ack, then present the result
				StMemRel:
					if (!memAck_i)
						state <= StFwd;
				StAck:
					if (!ldReq_i)
						state <= StAckRel;
				StAckRel:
				begin
					ldAckQ <= 1'b0;
					state  <= StIdle;
				end
				default:
					state <= StIdle;
			endcase
		end
	end

	// lookup captured at acceptance, data replaced by memory if needed
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			fwdQ     <= fwdHit_i;
			violQ    <= partialMatch_i;
			resultQ  <= fwdData_i;
			memAddrQ <= {ldAddr_i[AddrW-1:OffsetW], {OffsetW{1'b0}}};
		end
		else if (memDone)
			resultQ <= memData_i;
	end

	assign ldAck_o     = ldAckQ;
	assign ldData_o    = resultQ;
	assign ldFwd_o     = fwdQ;
	assign ldViolate_o = violQ;
	assign memReq_o    = memReqQ;
	// word aligned, stable while req is high
	assign memAddr_o   = memAddrQ;

endmodule

//--- rtl/loadExecPath.sv
// Load execution path
// store queue, load queue table, disambiguation and the load issue
// control, one load in flight at a time
`timescale 1ns/1ps

module loadExecPath (
	input  logic              clk,
	input  logic              reset,
	input  logic              stDispatch_i,
	input  logic              stExec_i,
	input  lsqPkg::stqIdx_t   stExecId_i,
	input  lsqPkg::addr_t     stAddr_i,
	input  lsqPkg::data_t     stData_i,
	input  lsqPkg::memSize_t  stSize_i,
	input  logic              commitSt_i,
	output lsqPkg::addr_t     stCommitAddr_o,
	output lsqPkg::data_t     stCommitData_o,
	output lsqPkg::memSize_t  stCommitSize_o,
	input  logic              ldDispatch_i,
	input  lsqPkg::ldqIdx_t   ldDispatchId_i,
	input  logic              commitLd_i,
	input  lsqPkg::ldqIdx_t   commitLdId_i,
	input  logic              ldReq_i,
	output logic              ldAck_o,
	input  lsqPkg::ldqIdx_t   ldId_i,
	input  lsqPkg::addr_t     ldAddr_i,
	input  lsqPkg::memSize_t  ldSize_i,
	output lsqPkg::data_t     ldData_o,
	output logic              ldFwd_o,
	output logic              ldViolate_o,
	output logic              memReq_o,
	output lsqPkg::addr_t     memAddr_o,
	input  logic              memAck_i,
	input  lsqPkg::data_t     memData_i
);
	import lsqPkg::*;

	stqIdx_t             stqHead;
	stqIdx_t             stqTail;
	stqCnt_t             stqCount;
	logic [StqDepth-1:0] stqAddrValid;
	logic [StqDepth-1:0] wordMatch;
	logic [StqDepth-1:0] offsetMatch;
	logic [StqDepth-1:0] sizeSmall;
	data_t               fwdData;
	stqIdx_t             lastSt;
	logic                lastStValid;
	logic                fwdHit;
	stqIdx_t             fwdIdx;
	logic                partialMatch;

	// store entries and load compare, driven from the held request
	storeQueue u_storeQueue (
		.clk            (clk),
		.reset          (reset),
		.stDispatch_i   (stDispatch_i),
		.stExec_i       (stExec_i),
		.stExecId_i     (stExecId_i),
		.stAddr_i       (stAddr_i),
		.stData_i       (stData_i),
		.stSize_i       (stSize_i),
		.commitSt_i     (commitSt_i),
		.ldAddr_i       (ldAddr_i),
		.ldSize_i       (ldSize_i),
		.fwdIdx_i       (fwdIdx),
		.head_o         (stqHead),
		.tail_o         (stqTail),
		.count_o        (stqCount),
		.addrValid_o    (stqAddrValid),
		.wordMatch_o    (wordMatch),
		.offsetMatch_o  (offsetMatch),
		.sizeSmall_o    (sizeSmall),
		.fwdData_o      (fwdData),
		.stCommitAddr_o (stCommitAddr_o),
		.stCommitData_o (stCommitData_o),
		.stCommitSize_o (stCommitSize_o)
	);

	// last older store per load
	loadQueue u_loadQueue (
		.clk            (clk),
		.reset          (reset),
		.ldDispatch_i   (ldDispatch_i),
		.ldDispatchId_i (ldDispatchId_i),
		.commitLd_i     (commitLd_i),
		.commitLdId_i   (commitLdId_i),
		.commitSt_i     (commitSt_i),
		.stqHead_i      (stqHead),
		.stqTail_i      (stqTail),
		.stqCount_i     (stqCount),
		.ldId_i         (ldId_i),
		.lastSt_o       (lastSt),
		.lastStValid_o  (lastStValid)
	);

	loadDisambig u_loadDisambig (
		.stqHead_i      (stqHead),
		.lastSt_i       (lastSt),
		.lastStValid_i  (lastStValid),
		.addrValid_i    (stqAddrValid),
		.wordMatch_i    (wordMatch),
		.offsetMatch_i  (offsetMatch),
		.sizeSmall_i    (sizeSmall),
		.fwdHit_o       (fwdHit),
		.fwdIdx_o       (fwdIdx),
		.partialMatch_o (partialMatch)
	);

	// handshakes toward the requester and memory
	loadIssueCtrl u_loadIssueCtrl (
		.clk            (clk),
		.reset          (reset),
		.ldReq_i        (ldReq_i),
		.ldAddr_i       (ldAddr_i),
		.fwdHit_i       (fwdHit),
		.partialMatch_i (partialMatch),
		.fwdData_i      (fwdData),
		.memAck_i       (memAck_i),
		.memData_i      (memData_i),
		.ldAck_o        (ldAck_o),
		.ldData_o       (ldData_o),
		.ldFwd_o        (ldFwd_o),
		.ldViolate_o    (ldViolate_o),
		.memReq_o       (memReq_o),
		.memAddr_o      (memAddr_o)
	);

endmodule

//--- testbench/tbLoadExecPath.sv
// Testbench for the load execution path
// directed tests for forwarding, partial overlap, window limits and
// memory back-pressure, with a random-latency memory on the read handshake
`timescale 1ns/1ps

module tbLoadExecPath;
	import lsqPkg::*;

	// all tests together take a few hundred cycles
	localparam int          CycleLimit = 2000;
	localparam int unsigned Seed       = 32'h4f620492;
	localparam data_t       MemKey     = 32'h5a3c96e1;

	logic     clk = 1'b0;
	logic     reset;
	logic     stDispatch_i;
	logic     stExec_i;
	stqIdx_t  stExecId_i;
	addr_t    stAddr_i;
	data_t    stData_i;
	memSize_t stSize_i;
	logic     commitSt_i;
	addr_t    stCommitAddr_o;
	data_t    stCommitData_o;
	memSize_t stCommitSize_o;
	logic     ldDispatch_i;
	ldqIdx_t  ldDispatchId_i;
	logic     commitLd_i;
	ldqIdx_t  commitLdId_i;
	logic     ldReq_i;
	logic     ldAck_o;
	ldqIdx_t  ldId_i;
	addr_t    ldAddr_i;
	memSize_t ldSize_i;
	data_t    ldData_o;
	logic     ldFwd_o;
	logic     ldViolate_o;
	logic     memReq_o;
	addr_t    memAddr_o;
	logic     memAck_i;
	data_t    memData_i;

	// own copy of the store queue
	stqIdx_t     sbHead;
	stqIdx_t     sbTail;
	addr_t       sbAddr [StqDepth];
	data_t       sbData [StqDepth];
	memSize_t    sbSize [StqDepth];
	ldqIdx_t     nextLd;
	int          cycleCount = 0;
	int          memCount = 0;
	addr_t       memAddrSeen;
	int unsigned memDelay [32];
	data_t       resData;
	logic        resFwd;
	logic        resViol;
	int          resLat;
	int          resMem;

	loadExecPath u_loadExecPath (.*);

	always #5 clk = ~clk;

	always @(posedge clk)
	begin
		cycleCount++;
		if (cycleCount >= CycleLimit)
		begin
			$display("timeout: run did not finish within %0d cycles", CycleLimit);
			$display("Simulation failed");
			$fatal(1);
		end
	end

	// memory answers after 0 to 5 cycles with the word address XOR a key
	initial
	begin
		memAck_i  = 1'b0;
		memData_i = '0;
		forever
		begin
			@(negedge clk);
			if (memReq_o && !memAck_i)
			begin
				memAddrSeen = memAddr_o;
				repeat (memDelay[memCount % 32]) @(negedge clk);
				memCount++;
				memData_i = memAddr_o ^ MemKey;
				memAck_i  = 1'b1;
				while (memReq_o)
					@(negedge clk);
				memAck_i = 1'b0;
			end
		end
	end

	function automatic data_t memWord(addr_t a);
		return {a[AddrW-1:OffsetW], {OffsetW{1'b0}}} ^ MemKey;
	endfunction

	task automatic checkEq(string test, string what, data_t exp, data_t act);
		assert (exp == act)
		else
		begin
			$display("** Error %s: %s expected %h actual %h", test, what, exp, act);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	task automatic checkLoad(string test, data_t expData, logic expFwd, logic expViol);
		checkEq(test, "load data", expData, resData);
		checkEq(test, "forward flag", data_t'(expFwd), data_t'(resFwd));
		checkEq(test, "violation flag", data_t'(expViol), data_t'(resViol));
	endtask

	// all drive tasks start and end on a falling edge
	task automatic dispatchStore(output stqIdx_t idx);
		idx          = sbTail;
		stDispatch_i = 1'b1;
		@(negedge clk);
		stDispatch_i = 1'b0;
		sbTail       = sbTail + 1'b1;
	endtask

	task automatic execStore(stqIdx_t idx, addr_t a, data_t d, memSize_t s);
		stExecId_i  = idx;
		stAddr_i    = a;
		stData_i    = d;
		stSize_i    = s;
		stExec_i    = 1'b1;
		sbAddr[idx] = a;
		sbData[idx] = d;
		sbSize[idx] = s;
		@(negedge clk);
		stExec_i = 1'b0;
	endtask

	// head fields must be on the commit outputs before the strobe
	task automatic commitStore(string test);
		checkEq(test, "commit address", sbAddr[sbHead], stCommitAddr_o);
		checkEq(test, "commit data", sbData[sbHead], stCommitData_o);
		checkEq(test, "commit size", data_t'(sbSize[sbHead]), data_t'(stCommitSize_o));
		commitSt_i = 1'b1;
		@(negedge clk);
		commitSt_i = 1'b0;
		sbHead     = sbHead + 1'b1;
	endtask

	task automatic drainStores(string test);
		while (sbHead != sbTail)
			commitStore(test);
	endtask

	task automatic dispatchLoad(output ldqIdx_t id);
		id             = nextLd;
		ldDispatchId_i = id;
		ldDispatch_i   = 1'b1;
		@(negedge clk);
		ldDispatch_i = 1'b0;
		nextLd       = nextLd + 1'b1;
	endtask

	task automatic commitLoad(ldqIdx_t id);
		commitLdId_i = id;
		commitLd_i   = 1'b1;
		@(negedge clk);
		commitLd_i = 1'b0;
	endtask

	// full req/ack cycle with req held for hold extra cycles after ack
	task automatic runLoad(string test, ldqIdx_t id, addr_t a, memSize_t s, int hold);
		int memBefore;

		assert (!ldAck_o)
		else
		begin
			$display("%s: load ack still high before a new request", test);
			$display("Simulation failed");
			$fatal(1);
		end
		memBefore = memCount;
		ldId_i    = id;
		ldAddr_i  = a;
		ldSize_i  = s;
		ldReq_i   = 1'b1;
		resLat    = 0;
		while (!ldAck_o)
		begin
			@(negedge clk);
			resLat++;
		end
		resData = ldData_o;
		resFwd  = ldFwd_o;
		resViol = ldViolate_o;
		resMem  = memCount - memBefore;
		if (!resFwd)
			checkEq(test, "memory address", {a[AddrW-1:OffsetW], 2'b00}, memAddrSeen);
		repeat (hold) @(negedge clk);
		// late req drop keeps ack and result up
		checkEq(test, "held ack", 1, data_t'(ldAck_o));
		checkEq(test, "held data", resData, ldData_o);
		ldReq_i = 1'b0;
		while (ldAck_o)
			@(negedge clk);
	endtask

	task automatic testReset();
		ldqIdx_t ld;

		checkEq("reset", "load ack", '0, data_t'(ldAck_o));
		checkEq("reset", "memory req", '0, data_t'(memReq_o));
		dispatchLoad(ld);
		runLoad("reset", ld, 32'h00001042, SizeWord, 0);
		checkLoad("reset", memWord(32'h00001042), 1'b0, 1'b0);
		commitLoad(ld);
	endtask

	task automatic testForward();
		stqIdx_t st;
		ldqIdx_t ld;
		data_t   d;

		d = $urandom;
		dispatchStore(st);
		execStore(st, 32'h00002000, d, SizeWord);
		dispatchLoad(ld);
		runLoad("forward", ld, 32'h00002000, SizeWord, 1);
		checkLoad("forward", d, 1'b1, 1'b0);
		// sampling edge plus one
		checkEq("forward", "ack latency", 2, resLat);
		checkEq("forward", "memory reads", 0, resMem);
		commitLoad(ld);
		drainStores("forward");
	endtask

	task automatic testYoungest();
		stqIdx_t st0;
		stqIdx_t st1;
		ldqIdx_t ld;

		dispatchStore(st0);
		dispatchStore(st1);
		execStore(st1, 32'h00003004, 32'h1111beef, SizeWord);
		execStore(st0, 32'h00003004, 32'h2222dead, SizeWord);
		dispatchLoad(ld);
		runLoad("youngest", ld, 32'h00003004, SizeWord, 0);
		checkLoad("youngest", 32'h1111beef, 1'b1, 1'b0);
		commitLoad(ld);
		drainStores("youngest");
	endtask

	task automatic testPartial();
		stqIdx_t st;
		ldqIdx_t ld;

		// byte store inside the loaded word
		dispatchStore(st);
		execStore(st, 32'h00004008, 32'h000000a5, SizeByte);
		dispatchLoad(ld);
		runLoad("partial", ld, 32'h00004008, SizeWord, 0);
		checkLoad("partial", memWord(32'h00004008), 1'b0, 1'b1);
		commitLoad(ld);
		drainStores("partial");
		// wider store covering a half load returns its raw word
		dispatchStore(st);
		execStore(st, 32'h00005000, 32'h87654321, SizeWord);
		dispatchLoad(ld);
		runLoad("partial", ld, 32'h00005000, SizeHalf, 0);
		checkLoad("partial", 32'h87654321, 1'b1, 1'b0);
		commitLoad(ld);
		drainStores("partial");
	endtask

	task automatic testWindow();
		stqIdx_t stA;
		stqIdx_t stB;
		ldqIdx_t ld;

		// younger store outside the load's window
		dispatchStore(stA);
		execStore(stA, 32'h00007000, 32'h0badf00d, SizeWord);
		dispatchLoad(ld);
		dispatchStore(stB);
		execStore(stB, 32'h00006000, 32'h13572468, SizeWord);
		runLoad("window", ld, 32'h00006000, SizeWord, 0);
		checkLoad("window", memWord(32'h00006000), 1'b0, 1'b0);
		commitLoad(ld);
		drainStores("window");
		// window wraps onto slot 0, its stale 2000 entry has no address yet
		dispatchStore(stA);
		execStore(stA, 32'h00006100, 32'h24681357, SizeWord);
		dispatchStore(stB);
		dispatchLoad(ld);
		runLoad("window", ld, 32'h00002000, SizeWord, 2);
		checkLoad("window", memWord(32'h00002000), 1'b0, 1'b0);
		commitLoad(ld);
		execStore(stB, 32'h00002000, 32'h7e57da7a, SizeWord);
		drainStores("window");
		// matching store leaves before the load runs
		dispatchStore(stA);
		execStore(stA, 32'h00006200, 32'h5eed5eed, SizeHalf);
		dispatchLoad(ld);
		commitStore("window");
		runLoad("window", ld, 32'h00006200, SizeHalf, 0);
		checkLoad("window", memWord(32'h00006200), 1'b0, 1'b0);
		commitLoad(ld);
	endtask

	task automatic testBackPressure();
		ldqIdx_t ld;
		addr_t   a;

		for (int i = 0; i < 12; i++)
		begin
			a = addr_t'($urandom);
			dispatchLoad(ld);
			runLoad("backpressure", ld, a, SizeWord, int'($urandom % 4));
			checkLoad("backpressure", memWord(a), 1'b0, 1'b0);
			commitLoad(ld);
		end
	endtask

	initial
	begin
		void'($urandom(Seed));
		for (int i = 0; i < 32; i++)
			memDelay[i] = $urandom % 6;
		reset          = 1'b1;
		stDispatch_i   = 1'b0;
		stExec_i       = 1'b0;
		stExecId_i     = '0;
		stAddr_i       = '0;
		stData_i       = '0;
		stSize_i       = SizeWord;
		commitSt_i     = 1'b0;
		ldDispatch_i   = 1'b0;
		ldDispatchId_i = '0;
		commitLd_i     = 1'b0;
		commitLdId_i   = '0;
		ldReq_i        = 1'b0;
		ldId_i         = '0;
		ldAddr_i       = '0;
		ldSize_i       = SizeWord;
		sbHead         = '0;
		sbTail         = '0;
		nextLd         = '0;
		repeat (8) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		testReset();
		testForward();
		testYoungest();
		testPartial();
		testWindow();
		testBackPressure();
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

//--- all.f
rtl/lsqPkg.sv
rtl/storeQueue.sv
rtl/loadQueue.sv
rtl/loadDisambig.sv
rtl/loadIssueCtrl.sv
rtl/loadExecPath.sv
testbench/tbLoadExecPath.sv

//--- run.sh
#!/bin/sh
# build and run the load execution path testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tbLoadExecPath \
	-Mdir obj_dir -o simTb
status=$?
if [ $status -ne 0 ]; then
	echo "build failed with status $status"
	exit 1
fi

./obj_dir/simTb
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit 1
fi
exit 0
